// ==== verilog/mips_pkg.sv ====
package mips_pkg;

	//////////////////////////////
	// Widths
	localparam int data_w     = 32;
	localparam int reg_addr_w = 5;

	//////////////////////////////
	// ALU operations
	typedef enum logic [3:0] {
		alu_add = 4'd0,
		alu_sub = 4'd1,
		alu_and = 4'd2,
		alu_or  = 4'd3,
		alu_xor = 4'd4,
		alu_nor = 4'd5,
		alu_slt = 4'd6,
		alu_sll = 4'd7,
		alu_srl = 4'd8,
		alu_sra = 4'd9
	} alu_op_t;

	// Primary opcodes
	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_beq   = 6'h04;
	localparam logic [5:0] op_addi  = 6'h08;
	localparam logic [5:0] op_slti  = 6'h0a;
	localparam logic [5:0] op_andi  = 6'h0c;
	localparam logic [5:0] op_ori   = 6'h0d;

	// R-type funct field
	localparam logic [5:0] funct_sll = 6'h00;
	localparam logic [5:0] funct_srl = 6'h02;
	localparam logic [5:0] funct_sra = 6'h03;
	localparam logic [5:0] funct_add = 6'h20;
	localparam logic [5:0] funct_sub = 6'h22;
	localparam logic [5:0] funct_and = 6'h24;
	localparam logic [5:0] funct_or  = 6'h25;
	localparam logic [5:0] funct_xor = 6'h26;
	localparam logic [5:0] funct_nor = 6'h27;
	localparam logic [5:0] funct_slt = 6'h2a;

	//////////////////////////////
	// Instruction word formats
	typedef struct packed {
		logic [5:0]            opcode;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
		logic [reg_addr_w-1:0] rd;
		logic [4:0]            shamt;
		logic [5:0]            funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]            opcode;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
		logic [15:0]           imm;
	} i_fmt_t;

	// Same word, seen as either format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_u;

	// Controls handed from decode to execute
	typedef struct packed {
		alu_op_t alu_op;
		logic    alu_src;
		logic    reg_dst;
		logic    shamt_sel;
		logic    reg_write;
		logic    is_branch;
	} exec_ctrl_t;

endpackage

// ==== verilog/exec_if.sv ====
`timescale 1ns/1ps

interface exec_if;

	logic                              valid;
	mips_pkg::exec_ctrl_t              ctrl;
	logic [mips_pkg::data_w-1:0]       rs_data;
	logic [mips_pkg::data_w-1:0]       rt_data;
	logic [mips_pkg::data_w-1:0]       imm_ext;
	logic [mips_pkg::data_w-1:0]       shamt_ext;
	logic [mips_pkg::reg_addr_w-1:0]   rd;
	logic [mips_pkg::reg_addr_w-1:0]   rt;
	logic [mips_pkg::data_w-1:0]       next_pc;

	// Decode side
	modport dec (
		output valid, ctrl, rs_data, rt_data, imm_ext, shamt_ext,
		output rd, rt, next_pc
	);

	// Execute side
	modport exe (
		input valid, ctrl, rs_data, rt_data, imm_ext, shamt_ext,
		input rd, rt, next_pc
	);

endinterface

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [mips_pkg::reg_addr_w-1:0]     rd_addr_a,
	input  logic [mips_pkg::reg_addr_w-1:0]     rd_addr_b,
	output logic [mips_pkg::data_w-1:0]         rd_data_a,
	output logic [mips_pkg::data_w-1:0]         rd_data_b,
	input  logic                                wr_en,
	input  logic [mips_pkg::reg_addr_w-1:0]     wr_addr,
	input  logic [mips_pkg::data_w-1:0]         wr_data
);

	localparam int depth = 2 ** mips_pkg::reg_addr_w;

	logic [mips_pkg::data_w-1:0] regs [depth];

	// Write port, register 0 never changes
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < depth; i++)
				regs[i] <= '0;
		end
		else if (wr_en && (wr_addr != '0))
		begin
			regs[wr_addr] <= wr_data;
		end
	end

	//////////////////////////////
	// Combinational read ports
	always_comb
	begin
		rd_data_a = regs[rd_addr_a];
		rd_data_b = regs[rd_addr_b];
		if (rd_addr_a == '0)
			rd_data_a = '0;
		if (rd_addr_b == '0)
			rd_data_b = '0;
	end

endmodule

// ==== verilog/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                req,
	input  logic [mips_pkg::data_w-1:0]         instr,
	input  logic [mips_pkg::data_w-1:0]         pc,
	input  logic                                ack,
	output logic [mips_pkg::reg_addr_w-1:0]     rd_addr_a,
	output logic [mips_pkg::reg_addr_w-1:0]     rd_addr_b,
	input  logic [mips_pkg::data_w-1:0]         rd_data_a,
	input  logic [mips_pkg::data_w-1:0]         rd_data_b,
	exec_if.dec                                 ex
);

	mips_pkg::instr_u     word;
	mips_pkg::exec_ctrl_t ctrl;
	logic                 busy;
	logic                 accept;

	assign word      = instr;
	assign accept    = req && !busy;
	assign rd_addr_a = word.i.rs;
	assign rd_addr_b = word.i.rt;

	//////////////////////////////
	// Control decode
	always_comb
	begin
		ctrl           = '0;
		ctrl.alu_op    = mips_pkg::alu_add;
		ctrl.reg_write = 1'b1;
		case (word.r.opcode)
			mips_pkg::op_rtype:
			begin
				ctrl.reg_dst = 1'b1;
				case (word.r.funct)
					mips_pkg::funct_add: ctrl.alu_op = mips_pkg::alu_add;
					mips_pkg::funct_sub: ctrl.alu_op = mips_pkg::alu_sub;
					mips_pkg::funct_and: ctrl.alu_op = mips_pkg::alu_and;
					mips_pkg::funct_or:  ctrl.alu_op = mips_pkg::alu_or;
					mips_pkg::funct_xor: ctrl.alu_op = mips_pkg::alu_xor;
					mips_pkg::funct_nor: ctrl.alu_op = mips_pkg::alu_nor;
					mips_pkg::funct_slt: ctrl.alu_op = mips_pkg::alu_slt;
					mips_pkg::funct_sll:
					begin
						ctrl.alu_op    = mips_pkg::alu_sll;
						ctrl.shamt_sel = 1'b1;
					end
					mips_pkg::funct_srl:
					begin
						ctrl.alu_op    = mips_pkg::alu_srl;
						ctrl.shamt_sel = 1'b1;
					end
					mips_pkg::funct_sra:
					begin
						ctrl.alu_op    = mips_pkg::alu_sra;
						ctrl.shamt_sel = 1'b1;
					end
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			mips_pkg::op_addi: ctrl.alu_src = 1'b1;
			mips_pkg::op_andi:
			begin
				ctrl.alu_op  = mips_pkg::alu_and;
				ctrl.alu_src = 1'b1;
			end
			mips_pkg::op_ori:
			begin
				ctrl.alu_op  = mips_pkg::alu_or;
				ctrl.alu_src = 1'b1;
			end
			mips_pkg::op_slti:
			begin
				ctrl.alu_op  = mips_pkg::alu_slt;
				ctrl.alu_src = 1'b1;
			end
			mips_pkg::op_beq:
			begin
				ctrl.alu_op    = mips_pkg::alu_sub;
				ctrl.is_branch = 1'b1;
			end
			// Unknown opcode runs as an add with no write
			default: ctrl.reg_write = 1'b0;
		endcase
		if (ctrl.is_branch)
			ctrl.reg_write = 1'b0;
	end

	//////////////////////////////
	// Handshake state
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			busy     <= 1'b0;
			ex.valid <= 1'b0;
		end
		else
		begin
			ex.valid <= accept;
			if (accept)
				busy <= 1'b1;
			else if (ack && !req)
				busy <= 1'b0;
		end
	end

	// Operands captured on acceptance
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			ex.ctrl      <= ctrl;
			ex.rs_data   <= rd_data_a;
			ex.rt_data   <= rd_data_b;
			ex.imm_ext   <= {{(mips_pkg::data_w-16){word.i.imm[15]}}, word.i.imm};
			ex.shamt_ext <= {{(mips_pkg::data_w-5){1'b0}}, word.r.shamt};
			ex.rd        <= word.r.rd;
			ex.rt        <= word.r.rt;
			ex.next_pc   <= pc + 32'd4;
		end
	end

endmodule

// ==== verilog/alu_execute.sv ====
`timescale 1ns/1ps

module alu_execute (
	input  logic                                clk,
	input  logic                                rst_n,
	exec_if.exe                                 ex,
	output logic                                ex_valid,
	output logic [mips_pkg::data_w-1:0]         alu_result,
	output logic                                alu_zero,
	output logic [mips_pkg::data_w-1:0]         branch_target,
	output logic [mips_pkg::reg_addr_w-1:0]     dest_reg,
	output logic                                reg_write
);

	logic [mips_pkg::data_w-1:0] src_a;
	logic [mips_pkg::data_w-1:0] src_b;
	logic [mips_pkg::data_w-1:0] alu_a;
	logic [mips_pkg::data_w-1:0] alu_b;
	logic [mips_pkg::data_w-1:0] alu_y;
	logic [4:0]                  sh;
	logic                        zero_flag;

	//////////////////////////////
	// Operand selection
	// Register or immediate
	assign src_b = ex.ctrl.alu_src ? ex.imm_ext : ex.rt_data;
	// Register or shift amount
	assign src_a = ex.ctrl.shamt_sel ? ex.shamt_ext : ex.rs_data;

	// Shifts swap operands, value on a and amount on b
	assign alu_a = ex.ctrl.shamt_sel ? src_b : src_a;
	assign alu_b = ex.ctrl.shamt_sel ? src_a : src_b;

	assign sh = alu_b[4:0];

	//////////////////////////////
	// ALU
	always_comb
	begin
		case (ex.ctrl.alu_op)
			mips_pkg::alu_add: alu_y = alu_a + alu_b;
			mips_pkg::alu_sub: alu_y = alu_a - alu_b;
			mips_pkg::alu_and: alu_y = alu_a & alu_b;
			mips_pkg::alu_or:  alu_y = alu_a | alu_b;
			mips_pkg::alu_xor: alu_y = alu_a ^ alu_b;
			mips_pkg::alu_nor: alu_y = ~(alu_a | alu_b);
			mips_pkg::alu_slt:
			begin
				alu_y = '0;
				alu_y[0] = $signed(alu_a) < $signed(alu_b);
			end
			mips_pkg::alu_sll: alu_y = alu_a << sh;
			mips_pkg::alu_srl: alu_y = alu_a >> sh;
			mips_pkg::alu_sra: alu_y = $unsigned($signed(alu_a) >>> sh);
			default:           alu_y = alu_a + alu_b;
		endcase
	end

	assign zero_flag = (alu_y == '0);

	//////////////////////////////
	// Output register
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			ex_valid <= 1'b0;
		else
			ex_valid <= ex.valid;
	end

	always_ff @(posedge clk)
	begin
		if (ex.valid)
		begin
			alu_result    <= alu_y;
			alu_zero      <= zero_flag;
			branch_target <= ex.next_pc + (ex.imm_ext << 2);
			reg_write     <= ex.ctrl.reg_write;
			if (ex.ctrl.reg_dst)
				dest_reg <= ex.rd;
			else
				dest_reg <= ex.rt;
		end
	end

endmodule

// ==== verilog/result_stage.sv ====
`timescale 1ns/1ps

module result_stage (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                req,
	input  logic                                ex_valid,
	input  logic [mips_pkg::data_w-1:0]         alu_result,
	input  logic                                alu_zero,
	input  logic [mips_pkg::data_w-1:0]         branch_target,
	input  logic [mips_pkg::reg_addr_w-1:0]     dest_reg,
	input  logic                                reg_write,
	output logic                                ack,
	output logic [mips_pkg::data_w-1:0]         result,
	output logic                                zero,
	output logic [mips_pkg::data_w-1:0]         branch_target_out,
	output logic [mips_pkg::reg_addr_w-1:0]     wr_reg,
	output logic                                wr_en,
	output logic [mips_pkg::reg_addr_w-1:0]     wr_addr,
	output logic [mips_pkg::data_w-1:0]         wr_data
);

	logic do_write;

	// Register 0 is never written
	assign do_write = ex_valid && reg_write && (dest_reg != '0);

	//////////////////////////////
	// Held outputs and ack
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ack               <= 1'b0;
			result            <= '0;
			zero              <= 1'b0;
			branch_target_out <= '0;
			wr_reg            <= '0;
			wr_en             <= 1'b0;
		end
		else
		begin
			// One-cycle write pulse
			wr_en <= do_write;
			if (ex_valid)
			begin
				ack               <= 1'b1;
				result            <= alu_result;
				zero              <= alu_zero;
				branch_target_out <= branch_target;
				wr_reg            <= dest_reg;
			end
			else if (ack && !req)
			begin
				ack <= 1'b0;
			end
		end
	end

	// Write data comes from the held result
	assign wr_addr = wr_reg;
	assign wr_data = result;

endmodule

// ==== verilog/mips_exec_top.sv ====
`timescale 1ns/1ps

module mips_exec_top (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                req,
	input  logic [mips_pkg::data_w-1:0]         instr,
	input  logic [mips_pkg::data_w-1:0]         pc,
	output logic                                ack,
	output logic [mips_pkg::data_w-1:0]         result,
	output logic                                zero,
	output logic [mips_pkg::data_w-1:0]         branch_target,
	output logic [mips_pkg::reg_addr_w-1:0]     wr_reg
);

	// Register file ports
	logic [mips_pkg::reg_addr_w-1:0] rd_addr_a;
	logic [mips_pkg::reg_addr_w-1:0] rd_addr_b;
	logic [mips_pkg::data_w-1:0]     rd_data_a;
	logic [mips_pkg::data_w-1:0]     rd_data_b;
	logic                            wr_en;
	logic [mips_pkg::reg_addr_w-1:0] wr_addr;
	logic [mips_pkg::data_w-1:0]     wr_data;

	// Execute to result
	logic                            ex_valid;
	logic [mips_pkg::data_w-1:0]     alu_result;
	logic                            alu_zero;
	logic [mips_pkg::data_w-1:0]     ex_target;
	logic [mips_pkg::reg_addr_w-1:0] dest_reg;
	logic                            reg_write;

	exec_if u_ex_if ();

	//////////////////////////////
	instr_decode u_decode (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.instr     (instr),
		.pc        (pc),
		.ack       (ack),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.ex        (u_ex_if.dec)
	);

	reg_file u_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data)
	);

	alu_execute u_execute (
		.clk           (clk),
		.rst_n         (rst_n),
		.ex            (u_ex_if.exe),
		.ex_valid      (ex_valid),
		.alu_result    (alu_result),
		.alu_zero      (alu_zero),
		.branch_target (ex_target),
		.dest_reg      (dest_reg),
		.reg_write     (reg_write)
	);

	result_stage u_result (
		.clk               (clk),
		.rst_n             (rst_n),
		.req               (req),
		.ex_valid          (ex_valid),
		.alu_result        (alu_result),
		.alu_zero          (alu_zero),
		.branch_target     (ex_target),
		.dest_reg          (dest_reg),
		.reg_write         (reg_write),
		.ack               (ack),
		.result            (result),
		.zero              (zero),
		.branch_target_out (branch_target),
		.wr_reg            (wr_reg),
		.wr_en             (wr_en),
		.wr_addr           (wr_addr),
		.wr_data           (wr_data)
	);

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int period_ns = 40
) (
	output logic clk
);

	// Free running, starts low
	initial
	begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

endmodule

// ==== test/mips_exec_asserts.sv ====
`timescale 1ns/1ps

module mips_exec_asserts (
	input logic clk,
	input logic rst_n,
	input logic req,
	input logic ack
);

	int ack_rise_fails = 0;
	int req_drop_fails = 0;
	int ack_fall_fails = 0;

	//////////////////////////////
	// Four-phase handshake rules
	ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> req)
	else
	begin
		$error("ack rose while req was low");
		ack_rise_fails++;
	end

	// Host keeps req up until it sees ack
	req_held: assert property (@(posedge clk) disable iff (!rst_n) (req && !ack) |=> req)
	else
	begin
		$error("req fell before ack was raised");
		req_drop_fails++;
	end

	ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n) $fell(req) |=> !ack)
	else
	begin
		$error("ack did not fall one edge after req fell");
		ack_fall_fails++;
	end

endmodule

bind mips_exec_top mips_exec_asserts u_asserts (
	.clk   (clk),
	.rst_n (rst_n),
	.req   (req),
	.ack   (ack)
);

// ==== test/tb_mips_exec.sv ====
`timescale 1ns/1ps

module tb_mips_exec;

	localparam int n_trans        = 32;
	localparam int timeout_cycles = n_trans * 8 + 50;

	logic        clk;
	logic        rst_n;
	logic        req;
	logic [31:0] instr;
	logic [31:0] pc;
	logic        ack;
	logic [31:0] result;
	logic        zero;
	logic [31:0] branch_target;
	logic [4:0]  wr_reg;

	// Register file mirror and expected outputs of the current instruction
	logic [31:0] mirror [32];
	logic [31:0] exp_result;
	logic        exp_zero;
	logic [31:0] exp_target;
	logic [4:0]  exp_wr_reg;
	logic [31:0] rng_state;
	logic [31:0] pc_next;
	logic        ack_prev;

	int cycles     = 0;
	int issued     = 0;
	int answered   = 0;
	int cmp_checks = 0;
	int cmp_errors = 0;
	int hs_checks  = 0;
	int hs_errors  = 0;
	int test_num   = 0;
	int err_mark   = 0;

	tb_clock_gen #(.period_ns(40)) u_clk (.clk(clk));

	mips_exec_top u_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.req           (req),
		.instr         (instr),
		.pc            (pc),
		.ack           (ack),
		.result        (result),
		.zero          (zero),
		.branch_target (branch_target),
		.wr_reg        (wr_reg)
	);

	//////////////////////////////
	// Helpers
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] rand_word();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] shamt);
		return {mips_pkg::op_rtype, rs, rt, rd, shamt, funct};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic int error_total();
		return cmp_errors + hs_errors + u_dut.u_asserts.ack_rise_fails
			+ u_dut.u_asserts.req_drop_fails + u_dut.u_asserts.ack_fall_fails;
	endfunction

	function automatic bit value_ok(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		bit ok;
		ok = (got === exp);
		assert (ok)
		else
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
		return ok;
	endfunction

	// Expected outputs from the instruction rules and the mirror update
	function automatic void ref_exec(
		input  logic [31:0] word,
		input  logic [31:0] pc_val,
		output logic [31:0] res,
		output logic        z,
		output logic [31:0] tgt,
		output logic [4:0]  dst
	);
		mips_pkg::instr_u w;
		logic [31:0]      a;
		logic [31:0]      b;
		logic [31:0]      imm;
		logic             writes;
		w      = word;
		a      = mirror[w.r.rs];
		b      = mirror[w.r.rt];
		imm    = {{16{w.i.imm[15]}}, w.i.imm};
		writes = 1'b1;
		dst    = w.i.rt;
		case (w.r.opcode)
			mips_pkg::op_rtype:
			begin
				dst = w.r.rd;
				case (w.r.funct)
					mips_pkg::funct_add: res = a + b;
					mips_pkg::funct_sub: res = a - b;
					mips_pkg::funct_and: res = a & b;
					mips_pkg::funct_or:  res = a | b;
					mips_pkg::funct_xor: res = a ^ b;
					mips_pkg::funct_nor: res = ~(a | b);
					mips_pkg::funct_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					// Shifts move rt by shamt and ignore rs
					mips_pkg::funct_sll: res = b << w.r.shamt;
					mips_pkg::funct_srl: res = b >> w.r.shamt;
					mips_pkg::funct_sra: res = $unsigned($signed(b) >>> w.r.shamt);
					default:
					begin
						res    = a + b;
						writes = 1'b0;
					end
				endcase
			end
			mips_pkg::op_addi: res = a + imm;
			mips_pkg::op_andi: res = a & imm;
			mips_pkg::op_ori:  res = a | imm;
			mips_pkg::op_slti: res = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
			mips_pkg::op_beq:
			begin
				res    = a - b;
				writes = 1'b0;
			end
			default:
			begin
				res    = a + b;
				writes = 1'b0;
			end
		endcase
		z   = (res == 32'd0);
		tgt = pc_val + 32'd4 + {imm[29:0], 2'b00};
		if (writes && dst != 5'd0)
			mirror[dst] = res;
	endfunction

	task automatic expect_hs(input string name, input logic [31:0] got, input logic [31:0] exp);
		hs_checks++;
		if (!value_ok(name, got, exp))
			hs_errors++;
	endtask

	task automatic expect_true(input bit cond, input string what);
		hs_checks++;
		assert (cond)
		else
		begin
			$display("Handshake error at %0t: %s", $time, what);
			hs_errors++;
		end
	endtask

	task automatic end_test(input string name);
		test_num++;
		$display("Test %0d %s: %0d errors", test_num, name, error_total() - err_mark);
		err_mark = error_total();
	endtask

	//////////////////////////////
	// One full req/ack transaction
	task automatic run_instr(input logic [31:0] word, input int hold);
		logic [31:0] held;
		int          latency;
		ref_exec(word, pc_next, exp_result, exp_zero, exp_target, exp_wr_reg);
		issued++;
		@(posedge clk);
		#2;
		req     = 1'b1;
		instr   = word;
		pc      = pc_next;
		latency = 0;
		do
		begin
			@(posedge clk);
			latency++;
			@(negedge clk);
		end
		while (!ack);
		expect_true(latency == 3, $sformatf("ack rose %0d edges after req, not 3", latency));
		held = result;
		repeat (hold)
		begin
			@(posedge clk);
			@(negedge clk);
			expect_true(ack, "ack dropped while req was still high");
			expect_hs("result", result, held);
		end
		@(posedge clk);
		#2;
		req     = 1'b0;
		pc_next = pc_next + 32'd4;
		@(posedge clk);
		@(negedge clk);
		expect_true(!ack, "ack still high one edge after req fell");
	endtask

	//////////////////////////////
	// Compare on each rising ack
	always @(negedge clk)
	begin
		if (rst_n && ack && !ack_prev)
		begin
			answered++;
			cmp_checks++;
			assert (answered == issued)
			else
			begin
				$display("ack at %0t does not match an outstanding instruction", $time);
				cmp_errors++;
			end
			cmp_checks += 4;
			if (!value_ok("result", result, exp_result))
				cmp_errors++;
			if (!value_ok("zero", {31'b0, zero}, {31'b0, exp_zero}))
				cmp_errors++;
			if (!value_ok("branch_target", branch_target, exp_target))
				cmp_errors++;
			if (!value_ok("wr_reg", {27'b0, wr_reg}, {27'b0, exp_wr_reg}))
				cmp_errors++;
		end
		ack_prev = ack;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > timeout_cycles)
		begin
			$display("Timeout after %0d cycles, the DUT stopped answering", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	//////////////////////////////
	// Stimulus
	initial
	begin
		logic [31:0] rnd;
		logic [5:0]  op;
		logic [5:0]  fn;
		logic [4:0]  src;
		int          total;
		rst_n     = 1'b0;
		req       = 1'b0;
		instr     = '0;
		pc        = '0;
		rng_state = 32'h87546a3c;
		pc_next   = 32'h0040_0000;
		for (int r = 0; r < 32; r++)
			mirror[r] = '0;
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// Idle outputs and register 0 after a write to it
		@(negedge clk);
		expect_hs("ack", {31'b0, ack}, 32'd0);
		expect_hs("result", result, 32'd0);
		expect_hs("zero", {31'b0, zero}, 32'd0);
		expect_hs("branch_target", branch_target, 32'd0);
		expect_hs("wr_reg", {27'b0, wr_reg}, 32'd0);
		rnd = rand_word();
		run_instr(enc_i(mips_pkg::op_addi, 5'd0, 5'd0, rnd[15:0]), 0);
		run_instr(enc_r(mips_pkg::funct_or, 5'd5, 5'd0, 5'd0, 5'd0), 0);
		end_test("reset and register 0");

		// Load r1 to r8 with immediates
		for (int k = 0; k < 8; k++)
		begin
			case (k / 2)
				0:       op = mips_pkg::op_addi;
				1:       op = mips_pkg::op_andi;
				2:       op = mips_pkg::op_ori;
				default: op = mips_pkg::op_slti;
			endcase
			src = (k < 2) ? 5'd0 : 5'(1 + (k % 2));
			rnd = rand_word();
			run_instr(enc_i(op, 5'(k + 1), src, rnd[15:0]), 0);
		end
		end_test("I-type loads");

		for (int k = 0; k < 7; k++)
		begin
			case (k)
				0:       fn = mips_pkg::funct_add;
				1:       fn = mips_pkg::funct_sub;
				2:       fn = mips_pkg::funct_and;
				3:       fn = mips_pkg::funct_or;
				4:       fn = mips_pkg::funct_xor;
				5:       fn = mips_pkg::funct_nor;
				default: fn = mips_pkg::funct_slt;
			endcase
			run_instr(enc_r(fn, 5'(k + 9), 5'(k + 1), 5'(k + 2), 5'd0), 0);
		end
		// Reads back two results written above
		run_instr(enc_r(mips_pkg::funct_add, 5'd16, 5'd9, 5'd10, 5'd0), 0);
		end_test("R-type ALU");

		// Negative value so sra and srl differ
		run_instr(enc_i(mips_pkg::op_addi, 5'd20, 5'd0, 16'h8123), 0);
		for (int k = 0; k < 6; k++)
		begin
			case (k % 3)
				0:       fn = mips_pkg::funct_sll;
				1:       fn = mips_pkg::funct_srl;
				default: fn = mips_pkg::funct_sra;
			endcase
			rnd = rand_word();
			// rs points at a live register that a shift has to ignore
			run_instr(enc_r(fn, 5'(k + 21), 5'd3, (k < 3) ? 5'd20 : 5'd1, rnd[4:0] | 5'd1), 0);
		end
		end_test("shifts");

		run_instr(enc_r(mips_pkg::funct_or, 5'd27, 5'd1, 5'd0, 5'd0), 0);
		rnd = rand_word();
		run_instr(enc_i(mips_pkg::op_beq, 5'd27, 5'd1, rnd[15:0]), 0);
		rnd = rand_word();
		run_instr(enc_i(mips_pkg::op_beq, 5'd2, 5'd1, rnd[15:0]), 0);
		rnd = rand_word();
		run_instr(enc_i(mips_pkg::op_beq, 5'd0, 5'd0, rnd[15:0]), 0);
		// Both beq rt registers must be unchanged
		run_instr(enc_r(mips_pkg::funct_xor, 5'd28, 5'd27, 5'd2, 5'd0), 0);
		end_test("beq");

		// rd doubles as rs and a repeated run would change the result
		run_instr(enc_r(mips_pkg::funct_add, 5'd29, 5'd29, 5'd9, 5'd0), 3);
		run_instr(enc_r(mips_pkg::funct_sub, 5'd29, 5'd29, 5'd1, 5'd0), 5);
		end_test("held req");

		total = error_total();
		$display("Summary: %0d tests, %0d checks, %0d errors", test_num,
			cmp_checks + hs_checks, total);
		if (total == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== all.f ====
verilog/mips_pkg.sv
verilog/exec_if.sv
verilog/reg_file.sv
verilog/instr_decode.sv
verilog/alu_execute.sv
verilog/result_stage.sv
verilog/mips_exec_top.sv
test/tb_clock_gen.sv
test/mips_exec_asserts.sv
test/tb_mips_exec.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mips_exec
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= *** PASSED ***

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
